// File: rtl/graph_pkg.sv
//#####################################################################
// Constants shared by the graphing pipeline and its testbench
// 640x480 timing, centred origin, parabola scale and palette
//#####################################################################

package graph_pkg;

    // Signed width of screen and function coordinates
    localparam int CORDW = 12;

    // Horizontal timing in pixels
    localparam logic signed [CORDW-1:0] H_ACTIVE = CORDW'(640);
    localparam logic signed [CORDW-1:0] H_FP     = CORDW'(16);   // Front porch
    localparam logic signed [CORDW-1:0] H_SYNC   = CORDW'(96);
    localparam logic signed [CORDW-1:0] H_BP     = CORDW'(48);   // Back porch
    localparam logic signed [CORDW-1:0] H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP;  // 800

    // Vertical timing in lines
    localparam logic signed [CORDW-1:0] V_ACTIVE = CORDW'(480);
    localparam logic signed [CORDW-1:0] V_FP     = CORDW'(10);
    localparam logic signed [CORDW-1:0] V_SYNC   = CORDW'(2);
    localparam logic signed [CORDW-1:0] V_BP     = CORDW'(33);
    localparam logic signed [CORDW-1:0] V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP;  // 525

    // Sync pulse windows, low inside [start, end)
    localparam logic signed [CORDW-1:0] H_SYNC_START = H_ACTIVE + H_FP;
    localparam logic signed [CORDW-1:0] H_SYNC_END   = H_SYNC_START + H_SYNC;
    localparam logic signed [CORDW-1:0] V_SYNC_START = V_ACTIVE + V_FP;
    localparam logic signed [CORDW-1:0] V_SYNC_END   = V_SYNC_START + V_SYNC;

    // Screen position of the function origin
    localparam logic signed [CORDW-1:0] X_OFFS = CORDW'(320);
    localparam logic signed [CORDW-1:0] Y_OFFS = CORDW'(240);

    // f(x) = (x*x) >> SQ_SHIFT
    localparam int SQ_SHIFT = 6;

    // Cycles from x,y valid to draw valid
    localparam int FUNC_LAT = 3;

    // Palette as {r, g, b} nibbles
    localparam logic [11:0] COL_AXES  = 12'hCCC;
    localparam logic [11:0] COL_CURVE = 12'h3BC;
    localparam logic [11:0] COL_BG    = 12'h222;
    localparam logic [11:0] COL_BLANK = 12'h000;  // Outside the active area

endpackage

// File: rtl/display_timing.sv
//#####################################################################
// Free-running 640x480 raster counters with sync, de and strobes
// Flags are registered so they line up with the sx, sy they describe
//#####################################################################

module display_timing (
    input  logic                               clk_pix,  // Pixel clock
    input  logic                               rst_n,
    output logic signed [graph_pkg::CORDW-1:0] sx,       // Screen column
    output logic signed [graph_pkg::CORDW-1:0] sy,       // Screen row
    output logic                               hsync,    // Active low
    output logic                               vsync,    // Active low
    output logic                               de,       // Active video
    output logic                               frame,    // First pixel of frame
    output logic                               line      // First pixel of line
);
    import graph_pkg::*;

    logic signed [CORDW-1:0] sx_next;  // Counter values one pixel ahead
    logic signed [CORDW-1:0] sy_next;
    logic                    last_col;
    logic                    last_row;
    logic                    hs_win;   // Inside the hsync window
    logic                    vs_win;

    always_comb begin
        last_col = (sx == H_TOTAL - CORDW'(1));
        last_row = (sy == V_TOTAL - CORDW'(1));
        sx_next  = last_col ? '0 : sx + CORDW'(1);  // Wrap at end of line
        sy_next  = sy;                              // Row holds within a line
        if (last_col) begin
            sy_next = last_row ? '0 : sy + CORDW'(1);
        end
    end

    // Sync windows decoded from the next position
    always_comb begin
        hs_win = (sx_next >= H_SYNC_START) && (sx_next < H_SYNC_END);
        vs_win = (sy_next >= V_SYNC_START) && (sy_next < V_SYNC_END);
    end

    // Counters and flags step together, so each flag matches the counters
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sx    <= '0;
            sy    <= '0;
            hsync <= 1'b1;  // Syncs idle high
            vsync <= 1'b1;
            de    <= 1'b0;
            frame <= 1'b0;  // No strobe for the pixel held in reset
            line  <= 1'b0;
        end else begin
            sx    <= sx_next;
            sy    <= sy_next;
            hsync <= ~hs_win;
            vsync <= ~vs_win;
            de    <= (sx_next < H_ACTIVE) && (sy_next < V_ACTIVE);
            frame <= (sx_next == '0) && (sy_next == '0);
            line  <= (sx_next == '0);  // Also high on the frame pixel
        end
    end

endmodule

// File: rtl/plot_coords.sv
//#####################################################################
// Screen to function coordinates, origin at the screen centre
// One register stage, y grows upward, axis marks the centre row/column
//#####################################################################

module plot_coords (
    input  logic                               clk_pix,
    input  logic                               rst_n,
    input  logic signed [graph_pkg::CORDW-1:0] sx,    // Screen column
    input  logic signed [graph_pkg::CORDW-1:0] sy,    // Screen row
    output logic signed [graph_pkg::CORDW-1:0] x,     // Function x
    output logic signed [graph_pkg::CORDW-1:0] y,     // Function y, up is positive
    output logic                               axis   // On the x or y axis
);
    import graph_pkg::*;

    logic signed [CORDW-1:0] x_calc;
    logic signed [CORDW-1:0] y_calc;
    logic                    on_y_axis;  // Vertical axis column
    logic                    on_x_axis;  // Horizontal axis row

    always_comb begin
        x_calc    = sx - X_OFFS;
        y_calc    = Y_OFFS - sy;  // Flip so rows above centre are positive
        on_y_axis = (sx == X_OFFS);
        on_x_axis = (sy == Y_OFFS);
    end

    // Everything leaves a cycle after the counters
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            x    <= '0;
            y    <= '0;
            axis <= 1'b0;
        end else begin
            x    <= x_calc;
            y    <= y_calc;
            axis <= on_y_axis || on_x_axis;
        end
    end

endmodule

// File: rtl/func_squared.sv
//#####################################################################
// Pipelined test of whether (x, y) lies on the scaled parabola
// Span between f(x) and f(x+1) is accepted so steep parts stay joined
//#####################################################################

module func_squared (
    input  logic                               clk_pix,
    input  logic                               rst_n,
    input  logic signed [graph_pkg::CORDW-1:0] x,
    input  logic signed [graph_pkg::CORDW-1:0] y,
    output logic                               draw   // Pixel is on the curve
);
    import graph_pkg::*;

    localparam int WW = 2 * CORDW;  // Width that holds a full square

    logic signed [WW-1:0] x_w;      // Sign-extended x
    logic signed [WW-1:0] x1_w;     // x + 1
    logic signed [WW-1:0] sq0;      // Stage 1
    logic signed [WW-1:0] sq1;
    logic signed [CORDW-1:0] y_s1;
    logic signed [WW-1:0] f0;       // Scaled squares
    logic signed [WW-1:0] f1;
    logic signed [WW-1:0] lo;       // Stage 2
    logic signed [WW-1:0] hi;
    logic signed [WW-1:0] y_s2;

    always_comb begin
        x_w  = WW'(x);
        x1_w = x_w + WW'(1);
        f0   = sq0 >>> SQ_SHIFT;  // Squares are never negative
        f1   = sq1 >>> SQ_SHIFT;
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sq0  <= '0;
            sq1  <= '0;
            y_s1 <= '0;
            lo   <= '0;
            hi   <= '0;
            y_s2 <= '0;
            draw <= 1'b0;
        end else begin
            // Stage 1 squares both column edges
            sq0  <= x_w * x_w;
            sq1  <= x1_w * x1_w;
            y_s1 <= y;
            // Stage 2 orders the bounds, left half of the curve falls
            if (f0 <= f1) begin
                lo <= f0;
                hi <= f1;
            end else begin
                lo <= f1;
                hi <= f0;
            end
            y_s2 <= WW'(y_s1);
            // Stage 3 inclusive range test
            draw <= (y_s2 >= lo) && (y_s2 <= hi);
        end
    end

endmodule

// File: rtl/pixel_colour.sv
//#####################################################################
// Aligns sync, de and axis with draw, then picks the output colour
// Colour and syncs leave together from one output register
//#####################################################################

module pixel_colour (
    input  logic       clk_pix,
    input  logic       rst_n,
    input  logic       hsync,      // Same cycle as the counters
    input  logic       vsync,
    input  logic       de,
    input  logic       axis,       // One cycle after the counters
    input  logic       draw,       // FUNC_LAT after axis
    output logic       dvi_hsync,
    output logic       dvi_vsync,
    output logic       dvi_de,
    output logic [3:0] dvi_r,
    output logic [3:0] dvi_g,
    output logic [3:0] dvi_b
);
    import graph_pkg::*;

    logic [FUNC_LAT:0]   hs_q;    // One extra stage for the coordinate register
    logic [FUNC_LAT:0]   vs_q;
    logic [FUNC_LAT:0]   de_q;
    logic [FUNC_LAT-1:0] ax_q;
    logic [11:0]         colour;

    // Priority blank, axes, curve, background
    always_comb begin
        if (!de_q[FUNC_LAT])         colour = COL_BLANK;
        else if (ax_q[FUNC_LAT-1])   colour = COL_AXES;
        else if (draw)               colour = COL_CURVE;
        else                         colour = COL_BG;
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            hs_q      <= '1;  // Idle syncs fill the pipe
            vs_q      <= '1;
            de_q      <= '0;
            ax_q      <= '0;
            dvi_hsync <= 1'b1;
            dvi_vsync <= 1'b1;
            dvi_de    <= 1'b0;
            {dvi_r, dvi_g, dvi_b} <= COL_BLANK;
        end else begin
            hs_q      <= {hs_q[FUNC_LAT-1:0], hsync};
            vs_q      <= {vs_q[FUNC_LAT-1:0], vsync};
            de_q      <= {de_q[FUNC_LAT-1:0], de};
            ax_q      <= {ax_q[FUNC_LAT-2:0], axis};
            dvi_hsync <= hs_q[FUNC_LAT];
            dvi_vsync <= vs_q[FUNC_LAT];
            dvi_de    <= de_q[FUNC_LAT];
            {dvi_r, dvi_g, dvi_b} <= colour;  // Nibbles r, g, b
        end
    end

endmodule

// File: rtl/graph_top.sv
//#####################################################################
// Function graphing pipeline with DVI-style 12-bit colour outputs
// Pixel outputs trail frame_start by five cycles
//#####################################################################

module graph_top (
    input  logic       clk_pix,      // 25.2 MHz class pixel clock
    input  logic       rst_n,
    output logic       dvi_hsync,
    output logic       dvi_vsync,
    output logic       dvi_de,
    output logic [3:0] dvi_r,
    output logic [3:0] dvi_g,
    output logic [3:0] dvi_b,
    output logic       frame_start   // Raster at (0, 0), not delayed
);
    import graph_pkg::*;

    logic signed [CORDW-1:0] sx;
    logic signed [CORDW-1:0] sy;
    logic                    hsync;
    logic                    vsync;
    logic                    de;
    logic signed [CORDW-1:0] x;      // Centred coordinates
    logic signed [CORDW-1:0] y;
    logic                    axis;
    logic                    draw;

    // Raster counters, line strobe only watched by assertions
    display_timing u_timing (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .sx      (sx),
        .sy      (sy),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de),
        .frame   (frame_start),
        .line    ()
    );

    plot_coords u_coords (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .sx      (sx),
        .sy      (sy),
        .x       (x),
        .y       (y),
        .axis    (axis)
    );

    func_squared u_func (
        .clk_pix (clk_pix),
        .rst_n   (rst_n),
        .x       (x),
        .y       (y),
        .draw    (draw)
    );

    pixel_colour u_colour (
        .clk_pix   (clk_pix),
        .rst_n     (rst_n),
        .hsync     (hsync),
        .vsync     (vsync),
        .de        (de),
        .axis      (axis),
        .draw      (draw),
        .dvi_hsync (dvi_hsync),
        .dvi_vsync (dvi_vsync),
        .dvi_de    (dvi_de),
        .dvi_r     (dvi_r),
        .dvi_g     (dvi_g),
        .dvi_b     (dvi_b)
    );

endmodule

// File: tb/graph_props.sv
//#####################################################################
// Assertions on the raster strobes and blanking, bound into graph_top
//#####################################################################

module graph_props (
    input logic       clk_pix,
    input logic       rst_n,
    input logic       frame,   // frame_start of the top level
    input logic       line,    // Internal line strobe
    input logic       dvi_de,
    input logic [3:0] dvi_r,
    input logic [3:0] dvi_g,
    input logic [3:0] dvi_b
);
    timeunit 1ns;
    timeprecision 1ps;

    int n_fail = 0;  // Read by the testbench at the end

    // First pixel of a frame is also first of a line
    a_frame_line : assert property (@(posedge clk_pix) disable iff (!rst_n)
        frame |-> line)
        else begin
            $error("frame strobe without line strobe");
            n_fail++;
        end

    // Single cycle strobe
    a_frame_pulse : assert property (@(posedge clk_pix) disable iff (!rst_n)
        frame |=> !frame)
        else begin
            $error("frame strobe held for two cycles");
            n_fail++;
        end

    a_blank_black : assert property (@(posedge clk_pix) disable iff (!rst_n)
        !dvi_de |-> ({dvi_r, dvi_g, dvi_b} == 12'h000))
        else begin
            $error("colour not black while de is low");
            n_fail++;
        end

endmodule

bind graph_top graph_props u_props (
    .clk_pix (clk_pix),
    .rst_n   (rst_n),
    .frame   (frame_start),
    .line    (u_timing.line),
    .dvi_de  (dvi_de),
    .dvi_r   (dvi_r),
    .dvi_g   (dvi_g),
    .dvi_b   (dvi_b)
);

// File: tb/graph_checker.sv
//#####################################################################
// Reference model and scoreboard for the graphing pipeline outputs
// Locks onto frame_start, then checks every pixel and the probes
//#####################################################################

module graph_checker (
    input  logic        clk_pix,
    input  logic        rst_n,
    input  logic        dvi_hsync,
    input  logic        dvi_vsync,
    input  logic        dvi_de,
    input  logic [3:0]  dvi_r,
    input  logic [3:0]  dvi_g,
    input  logic [3:0]  dvi_b,
    input  logic        frame_start,
    input  logic        probe_req,    // Probe entry is valid
    input  int          probe_sx,
    input  int          probe_sy,
    input  logic [11:0] probe_col,    // Colour of the expected class
    output logic        probe_done,
    output int          full_frames   // Frames checked from start to end
);
    timeunit 1ns;
    timeprecision 1ps;
    import graph_pkg::*;

    localparam int FRAME_CYC = int'(H_TOTAL) * int'(V_TOTAL);  // 420000
    localparam int DE_PIX    = int'(H_ACTIVE) * int'(V_ACTIVE);
    localparam int PIPE      = 5;  // frame_start to pixel outputs

    int              val_errs  = 0;
    int              probe_errs = 0;
    int              tmo_errs  = 0;
    logic            rst_applied = 1'b0;  // Power-on reset has reached the registers
    logic [PIPE-1:0] fs_hist;      // frame_start history with bit 0 newest
    logic            tracking;
    logic            fs_seen;      // A frame_start since reset
    logic            fs_late;      // Timeout already reported
    int              px;
    int              py;
    int              rd_cnt;       // Cycle index since reset release
    int              since_fs;
    int              de_cnt;
    logic [11:0]     exp_col;

    initial begin
        probe_done  = 1'b0;
        full_frames = 0;
    end

    function automatic int fsq(int v);
        return (v * v) >> SQ_SHIFT;
    endfunction

    // Colour from the screen position alone
    function automatic logic [11:0] model_colour(int cx, int cy);
        int fx;
        int fy;
        int a;
        int b;
        fx = cx - 320;
        fy = 240 - cy;  // Up is positive
        a  = fsq(fx);
        b  = fsq(fx + 1);
        if (cx >= 640 || cy >= 480)
            return 12'h000;
        if (cx == 320 || cy == 240)
            return 12'hCCC;
        if ((fy >= a && fy <= b) || (fy >= b && fy <= a))
            return 12'h3BC;
        return 12'h222;
    endfunction

    task automatic check_val(string name, logic [11:0] exp, logic [11:0] act);
        if (exp !== act) begin
            $display("FAILED %s at (%0d,%0d) expected %h got %h",
                     name, px, py, exp, act);
            val_errs++;
        end
    endtask

    task automatic check_idle();
        check_val("dvi_de", 12'(1'b0), 12'(dvi_de));
        check_val("dvi_hsync", 12'(1'b1), 12'(dvi_hsync));
        check_val("dvi_vsync", 12'(1'b1), 12'(dvi_vsync));
        check_val("dvi_rgb", 12'h000, {dvi_r, dvi_g, dvi_b});
        check_val("frame_start", 12'(1'b0), 12'(frame_start));
    endtask

    // Values read at a rising edge belong to the cycle that just ended
    always @(posedge clk_pix) begin
        if (!rst_n) begin
            if (rst_applied)
                check_idle();
            rst_applied = 1'b1;
            fs_hist  = '0;
            tracking = 1'b0;
            fs_seen  = 1'b0;
            fs_late  = 1'b0;
            rd_cnt   = 0;
            since_fs = 0;
        end else begin
            if (rd_cnt < PIPE)
                check_idle();  // Pipe still filling
            if (frame_start) begin
                if (fs_seen && since_fs != FRAME_CYC) begin
                    $display("frame_start period was %0d cycles instead of %0d",
                             since_fs, FRAME_CYC);
                    val_errs++;
                end
                if (!fs_seen && rd_cnt != FRAME_CYC) begin
                    $display("first frame_start after reset came at cycle %0d", rd_cnt);
                    val_errs++;
                end
                fs_seen  = 1'b1;
                since_fs = 0;
            end else if (!fs_seen && !fs_late && rd_cnt > FRAME_CYC + 8) begin
                $display("No frame_start seen within a frame after reset");
                tmo_errs++;
                fs_late = 1'b1;
            end
            // Raster position of the pixel on the outputs
            if (fs_hist[PIPE-1]) begin
                if (tracking) begin
                    if (de_cnt != DE_PIX) begin
                        $display("FAILED dvi_de count expected %h got %h", DE_PIX, de_cnt);
                        val_errs++;
                    end
                    full_frames++;
                end
                tracking = 1'b1;
                px       = 0;
                py       = 0;
                de_cnt   = 0;
            end else if (tracking) begin
                px++;
                if (px == 800) begin
                    px = 0;
                    py = (py == 524) ? 0 : py + 1;
                end
            end
            if (tracking) begin
                exp_col = model_colour(px, py);
                check_val("dvi_de", 12'(px < 640 && py < 480), 12'(dvi_de));
                check_val("dvi_hsync", 12'(!(px >= 656 && px < 752)), 12'(dvi_hsync));
                check_val("dvi_vsync", 12'(!(py >= 490 && py < 492)), 12'(dvi_vsync));
                check_val("dvi_r", 12'(exp_col[11:8]), 12'(dvi_r));
                check_val("dvi_g", 12'(exp_col[7:4]), 12'(dvi_g));
                check_val("dvi_b", 12'(exp_col[3:0]), 12'(dvi_b));
                if (dvi_de)
                    de_cnt++;
                if (probe_req && !probe_done && px == probe_sx && py == probe_sy) begin
                    if ({dvi_r, dvi_g, dvi_b} !== probe_col) begin
                        $display("FAILED probe dvi_rgb at (%0d,%0d) expected %h got %h",
                                 px, py, probe_col, {dvi_r, dvi_g, dvi_b});
                        probe_errs++;
                    end
                    probe_done <= 1'b1;
                end
            end
            fs_hist = {fs_hist[PIPE-2:0], frame_start};
            since_fs++;
            rd_cnt++;
        end
        if (!probe_req)
            probe_done <= 1'b0;
    end

    function automatic int total_errors();
        return val_errs + probe_errs + tmo_errs;
    endfunction

    task automatic report_counts(int assert_errs);
        $display("Errors: value %0d, probe %0d, timeout %0d, assertion %0d",
                 val_errs, probe_errs, tmo_errs, assert_errs);
    endtask

endmodule

// File: tb/graph_tb.sv
//#####################################################################
// Testbench for graph_top, probe table and a mid-frame reset
// Checking is done in graph_checker and the bound assertions
//#####################################################################

module graph_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import graph_pkg::*;

    localparam int FRAME_CYC = int'(H_TOTAL) * int'(V_TOTAL);
    localparam int N_PROBES  = 6;
    localparam int CLS_BLANK = 0;
    localparam int CLS_AXES  = 1;
    localparam int CLS_CURVE = 2;
    localparam int CLS_BG    = 3;

    logic        clk_pix;
    logic        rst_n;
    logic        dvi_hsync;
    logic        dvi_vsync;
    logic        dvi_de;
    logic [3:0]  dvi_r;
    logic [3:0]  dvi_g;
    logic [3:0]  dvi_b;
    logic        frame_start;
    logic        probe_req;
    int          probe_sx;
    int          probe_sy;
    logic [11:0] probe_col;
    logic        probe_done;
    int          full_frames;
    logic        timed_out;
    int          target;

    // sx, sy, expected class
    int probe_tab [N_PROBES][3] = '{
        '{320, 100, CLS_AXES},
        '{0,   240, CLS_AXES},
        '{328, 239, CLS_CURVE},   // f(8) = f(9) = 1, y = 1
        '{100, 100, CLS_BG},
        '{700, 10,  CLS_BLANK},   // Horizontal blanking
        '{10,  500, CLS_BLANK}    // Vertical blanking
    };

    always #2 clk_pix = ~clk_pix;  // 4 ns period

    graph_top u_dut (
        .clk_pix     (clk_pix),
        .rst_n       (rst_n),
        .dvi_hsync   (dvi_hsync),
        .dvi_vsync   (dvi_vsync),
        .dvi_de      (dvi_de),
        .dvi_r       (dvi_r),
        .dvi_g       (dvi_g),
        .dvi_b       (dvi_b),
        .frame_start (frame_start)
    );

    graph_checker u_chk (
        .clk_pix     (clk_pix),
        .rst_n       (rst_n),
        .dvi_hsync   (dvi_hsync),
        .dvi_vsync   (dvi_vsync),
        .dvi_de      (dvi_de),
        .dvi_r       (dvi_r),
        .dvi_g       (dvi_g),
        .dvi_b       (dvi_b),
        .frame_start (frame_start),
        .probe_req   (probe_req),
        .probe_sx    (probe_sx),
        .probe_sy    (probe_sy),
        .probe_col   (probe_col),
        .probe_done  (probe_done),
        .full_frames (full_frames)
    );

    function automatic logic [11:0] class_colour(int cls);
        case (cls)
            CLS_AXES:  return COL_AXES;
            CLS_CURVE: return COL_CURVE;
            CLS_BG:    return COL_BG;
            default:   return COL_BLANK;
        endcase
    endfunction

    task automatic wait_frames(int goal, int limit);
        int n;
        n = 0;
        while (!timed_out && full_frames < goal) begin
            @(negedge clk_pix);
            n++;
            if (n > limit) begin
                $display("Timed out waiting for a fully checked frame");
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic wait_probe(logic level, int limit);
        int n;
        n = 0;
        while (!timed_out && probe_done !== level) begin
            @(negedge clk_pix);
            n++;
            if (n > limit) begin
                $display("Timed out waiting for probe at (%0d,%0d)", probe_sx, probe_sy);
                timed_out = 1'b1;
            end
        end
    endtask

    initial begin
        clk_pix   = 1'b0;
        rst_n     = 1'b0;
        probe_req = 1'b0;
        probe_sx  = 0;
        probe_sy  = 0;
        probe_col = '0;
        timed_out = 1'b0;
        repeat (5) @(negedge clk_pix);
        rst_n = 1'b1;
        wait_frames(1, 3 * FRAME_CYC);
        for (int i = 0; i < N_PROBES; i++) begin
            @(negedge clk_pix);
            probe_sx  = probe_tab[i][0];
            probe_sy  = probe_tab[i][1];
            probe_col = class_colour(probe_tab[i][2]);
            probe_req = 1'b1;
            wait_probe(1'b1, 2 * FRAME_CYC);
            probe_req = 1'b0;
            wait_probe(1'b0, 10);
        end
        // Reset in the middle of a frame
        repeat (FRAME_CYC / 3) @(negedge clk_pix);
        rst_n = 1'b0;
        repeat (5) @(negedge clk_pix);
        rst_n  = 1'b1;
        target = full_frames + 1;
        wait_frames(target, 3 * FRAME_CYC);
        repeat (10) @(negedge clk_pix);
        u_chk.report_counts(u_dut.u_props.n_fail);
        if (timed_out || u_chk.total_errors() != 0 || u_dut.u_props.n_fail != 0) begin
            $display("Verification failed");
        end else begin
            $display("Verification passed");
        end
        $finish;
    end

endmodule

// File: graph_demo.f
rtl/graph_pkg.sv
rtl/display_timing.sv
rtl/plot_coords.sv
rtl/func_squared.sv
rtl/pixel_colour.sv
rtl/graph_top.sv
tb/graph_props.sv
tb/graph_checker.sv
tb/graph_tb.sv
